/* hw/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs (
    input  logic                     CLK_40,
    input  logic                     i_rst_n,
    input  readout_pkg::apb_req_t    i_apb,
    output readout_pkg::apb_rsp_t    o_apb,
    output readout_pkg::ctrl_t       o_ctrl,
    output logic                     o_clear,
    input  readout_pkg::count_t      i_trig_cnt,
    input  readout_pkg::count_t      i_lost_cnt,
    input  readout_pkg::fifo_level_t i_out_level
);
    import readout_pkg::*;

    ctrl_t     ctrl_q;
    logic      access;
    logic      wr_en;
    logic      addr_ok;
    apb_data_t rdata;

    // second cycle of a transfer, always completes
    assign access = i_apb.psel & i_apb.penable;
    assign wr_en  = access & i_apb.pwrite & addr_ok;

    // address decode and read mux
    always_comb
    begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (i_apb.paddr)
            REG_CTRL:     rdata = {30'h0, ctrl_q};
            REG_STATUS:   rdata = {27'h0, i_out_level};
            REG_TRIG_CNT: rdata = {4'h0, i_trig_cnt};
            REG_LOST:     rdata = {4'h0, i_lost_cnt};
            // write only, reads back zero
            REG_CLEAR:    rdata = '0;
            default:      addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
            ctrl_q <= '0;
        else if (wr_en && i_apb.paddr == REG_CTRL)
            ctrl_q <= ctrl_t'(i_apb.pwdata[1:0]);
    end

    // one cycle wide, recorders act on the same edge as the write
    assign o_clear = wr_en & (i_apb.paddr == REG_CLEAR) & i_apb.pwdata[0];

    assign o_ctrl = ctrl_q;

    assign o_apb.prdata  = rdata;
    assign o_apb.pready  = 1'b1;
    // unmapped address flagged only in the access phase
    assign o_apb.pslverr = access & ~addr_ok;

endmodule

/* hw/readout_pkg.sv */
package readout_pkg;

    // readout word and its header nibble
    typedef logic [31:0] data_word_t;
    typedef logic [3:0]  word_hdr_t;

    // apb bus fields
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // trigger number, lost count and timestamp
    typedef logic [27:0] count_t;

    // output fifo fill level, 0..16
    typedef logic [4:0]  fifo_level_t;

    // tdc word payload fields
    typedef logic [11:0] tdc_seq_t;
    typedef logic [15:0] tdc_len_t;

    // header codes in bits 31:28
    localparam word_hdr_t HDR_TRIG_NUM = 4'h8;
    localparam word_hdr_t HDR_TRIG_TS  = 4'h9;
    localparam word_hdr_t HDR_TDC      = 4'h4;

    // register map, byte addresses
    localparam apb_addr_t REG_CTRL     = 8'h00;
    localparam apb_addr_t REG_STATUS   = 8'h04;
    localparam apb_addr_t REG_TRIG_CNT = 8'h08;
    localparam apb_addr_t REG_LOST     = 8'h0C;
    localparam apb_addr_t REG_CLEAR    = 8'h10;

    // fifo sizes
    localparam int SRC_FIFO_LOG2  = 3;
    localparam int SRC_FIFO_DEPTH = 2 ** SRC_FIFO_LOG2;
    localparam int OUT_FIFO_LOG2  = 4;

    // source 0 is trigger, source 1 is tdc
    localparam int NUM_SRC    = 2;
    localparam int SRC_IDX_W  = $clog2(NUM_SRC);

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // trig_en lands on bit 0, tdc_en on bit 1
    typedef struct packed {
        logic tdc_en;
        logic trig_en;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        logic       hold;
        data_word_t data;
    } src_port_t;

endpackage

/* hw/readout_top.sv */
`timescale 1ns/1ps

module readout_top (
    input  logic                    CLK_40,
    input  logic                    i_rst_n,
    input  logic                    i_trigger,
    input  logic                    i_tdc_in,
    input  readout_pkg::apb_req_t   i_apb,
    output readout_pkg::apb_rsp_t   o_apb,
    input  logic                    i_rd_en,
    output logic                    o_rd_valid,
    output readout_pkg::data_word_t o_rd_data
);
    import readout_pkg::*;

    // source ports, index 0 trigger, index 1 tdc
    src_port_t          src [NUM_SRC];
    logic [NUM_SRC-1:0] src_pop;
    ctrl_t              ctrl;
    logic               clear;
    count_t             trig_cnt;
    count_t             lost_cnt;
    fifo_level_t        out_level;
    logic               arb_push;
    data_word_t         arb_data;
    logic               out_full;
    logic               out_empty;

    apb_regs apb_regs_i (
        .CLK_40     (CLK_40),
        .i_rst_n    (i_rst_n),
        .i_apb      (i_apb),
        .o_apb      (o_apb),
        .o_ctrl     (ctrl),
        .o_clear    (clear),
        .i_trig_cnt (trig_cnt),
        .i_lost_cnt (lost_cnt),
        .i_out_level(out_level)
    );

    trigger_recorder trigger_recorder_i (
        .CLK_40    (CLK_40),
        .i_rst_n   (i_rst_n),
        .i_trigger (i_trigger),
        .i_clear   (clear),
        .i_pop     (src_pop[0]),
        .o_src     (src[0]),
        .o_trig_cnt(trig_cnt),
        .o_lost_cnt(lost_cnt)
    );

    tdc_recorder tdc_recorder_i (
        .CLK_40  (CLK_40),
        .i_rst_n (i_rst_n),
        .i_tdc_in(i_tdc_in),
        .i_clear (clear),
        .i_pop   (src_pop[1]),
        .o_src   (src[1])
    );

    rr_arbiter rr_arbiter_i (
        .CLK_40    (CLK_40),
        .i_rst_n   (i_rst_n),
        .i_ctrl    (ctrl),
        .i_src     (src),
        .o_pop     (src_pop),
        .o_push    (arb_push),
        .o_data    (arb_data),
        .i_out_full(out_full)
    );

    // shared output buffer, host reads it first word fall through
    word_fifo #(
        .DEPTH_LOG2(OUT_FIFO_LOG2)
    ) out_fifo_i (
        .CLK_40 (CLK_40),
        .i_rst_n(i_rst_n),
        .i_push (arb_push),
        .i_data (arb_data),
        .i_pop  (i_rd_en),
        .o_data (o_rd_data),
        .o_empty(out_empty),
        .o_full (out_full),
        .o_level(out_level)
    );

    assign o_rd_valid = ~out_empty;

endmodule

/* hw/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                    CLK_40,
    input  logic                    i_rst_n,
    input  readout_pkg::ctrl_t      i_ctrl,
    input  readout_pkg::src_port_t  i_src [readout_pkg::NUM_SRC],
    output logic [readout_pkg::NUM_SRC-1:0] o_pop,
    output logic                    o_push,
    output readout_pkg::data_word_t o_data,
    input  logic                    i_out_full
);
    import readout_pkg::*;

    logic [NUM_SRC-1:0]   en;
    logic [NUM_SRC-1:0]   req;
    logic [SRC_IDX_W-1:0] last_q;
    logic                 hold_q;
    logic [SRC_IDX_W-1:0] gnt_idx;
    logic                 gnt_valid;
    logic                 move;

    // enable bits in source order
    assign en = {i_ctrl.tdc_en, i_ctrl.trig_en};

    always_comb
    begin
        for (int i = 0; i < NUM_SRC; i++)
            req[i] = i_src[i].valid & en[i];
    end

    always_comb
    begin
        int idx;
        gnt_valid = 1'b0;
        gnt_idx   = last_q;
        idx       = 0;
        if (hold_q)
        begin
            // locked to the source until the rest of its group is out
            gnt_valid = i_src[last_q].valid;
        end
        else
        begin
            // search starts one past the last grant
            for (int k = 1; k <= NUM_SRC; k++)
            begin
                idx = (int'(last_q) + k) % NUM_SRC;
                if (!gnt_valid && req[idx])
                begin
                    gnt_valid = 1'b1;
                    gnt_idx   = SRC_IDX_W'(idx);
                end
            end
        end
    end

    // nothing moves while the output fifo is full
    assign move = gnt_valid & ~i_out_full;

    always_comb
    begin
        for (int i = 0; i < NUM_SRC; i++)
            o_pop[i] = move && (int'(gnt_idx) == i);
    end

    assign o_push = move;
    assign o_data = i_src[gnt_idx].data;

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            last_q <= '0;
            hold_q <= 1'b0;
        end
        else if (move)
        begin
            last_q <= gnt_idx;
            // hold of the word just moved keeps the grant
            hold_q <= i_src[gnt_idx].hold;
        end
    end

endmodule

/* hw/tdc_recorder.sv */
`timescale 1ns/1ps

module tdc_recorder (
    input  logic                   CLK_40,
    input  logic                   i_rst_n,
    input  logic                   i_tdc_in,
    input  logic                   i_clear,
    input  logic                   i_pop,
    output readout_pkg::src_port_t o_src
);
    import readout_pkg::*;

    // sync pair plus edge reference
    logic [2:0] sync_q;
    logic       fall;
    tdc_len_t   len_cnt;
    tdc_len_t   len_q;
    tdc_seq_t   seq;
    logic       word_pend;
    logic       fifo_push;
    data_word_t fifo_dout;
    logic       fifo_empty;
    logic       fifo_full;

    assign fall = ~sync_q[1] & sync_q[2];

    // pending word is lost when the fifo is full
    assign fifo_push = word_pend & ~fifo_full;

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            sync_q    <= '0;
            len_cnt   <= '0;
            seq       <= '0;
            word_pend <= 1'b0;
        end
        else
        begin
            sync_q    <= {sync_q[1:0], i_tdc_in};
            word_pend <= fall;
            // high time in cycles saturating at all ones
            if (sync_q[1])
            begin
                if (len_cnt != '1)
                    len_cnt <= len_cnt + 1'b1;
            end
            else if (fall)
                len_cnt <= '0;
            // sequence only advances on words that were stored
            if (i_clear)
                seq <= '0;
            else if (fifo_push)
                seq <= seq + 1'b1;
        end
    end

    // length captured on the falling edge and written one cycle later
    always_ff @(posedge CLK_40)
    begin
        if (fall)
            len_q <= len_cnt;
    end

    word_fifo #(
        .DEPTH_LOG2(SRC_FIFO_LOG2)
    ) tdc_fifo_i (
        .CLK_40 (CLK_40),
        .i_rst_n(i_rst_n),
        .i_push (fifo_push),
        .i_data ({HDR_TDC, seq, len_q}),
        .i_pop  (i_pop),
        .o_data (fifo_dout),
        .o_empty(fifo_empty),
        .o_full (fifo_full),
        .o_level()
    );

    // single words are never held
    assign o_src.valid = ~fifo_empty;
    assign o_src.hold  = 1'b0;
    assign o_src.data  = fifo_dout;

endmodule

/* hw/trigger_recorder.sv */
`timescale 1ns/1ps

module trigger_recorder (
    input  logic                   CLK_40,
    input  logic                   i_rst_n,
    input  logic                   i_trigger,
    input  logic                   i_clear,
    input  logic                   i_pop,
    output readout_pkg::src_port_t o_src,
    output readout_pkg::count_t    o_trig_cnt,
    output readout_pkg::count_t    o_lost_cnt
);
    import readout_pkg::*;

    typedef enum logic {IDLE, WRITE_TS} trig_state_t;

    trig_state_t            state;
    // two sync flops plus one edge reference
    logic [2:0]             sync_q;
    logic                   rise;
    logic                   has_room;
    logic                   accept;
    count_t                 ts_cnt;
    count_t                 ts_q;
    count_t                 trig_cnt;
    count_t                 lost_cnt;
    logic                   fifo_push;
    data_word_t             fifo_din;
    data_word_t             fifo_dout;
    logic                   fifo_empty;
    logic [SRC_FIFO_LOG2:0] fifo_level;

    assign rise     = sync_q[1] & ~sync_q[2];
    // a pair needs two free slots
    assign has_room = (int'(fifo_level) <= SRC_FIFO_DEPTH - 2);
    assign accept   = (state == IDLE) & rise & has_room;

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            sync_q <= '0;
            ts_cnt <= '0;
        end
        else
        begin
            sync_q <= {sync_q[1:0], i_trigger};
            // free running timestamp, wraps
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // timestamp of the accepted edge, used one cycle later
    always_ff @(posedge CLK_40)
    begin
        if (rise)
            ts_q <= ts_cnt;
    end

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state    <= IDLE;
            trig_cnt <= '0;
            lost_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:     if (accept) state <= WRITE_TS;
                WRITE_TS: state <= IDLE;
                default:  state <= IDLE;
            endcase
            // clear wins over counting
            if (i_clear)
            begin
                trig_cnt <= '0;
                lost_cnt <= '0;
            end
            else if (accept)
                trig_cnt <= trig_cnt + 1'b1;
            else if (state == IDLE && rise)
                lost_cnt <= lost_cnt + 1'b1;
        end
    end

    // number word on accept, timestamp word right after
    assign fifo_push = accept | (state == WRITE_TS);
    assign fifo_din  = (state == WRITE_TS) ? {HDR_TRIG_TS, ts_q} : {HDR_TRIG_NUM, trig_cnt};

    word_fifo #(
        .DEPTH_LOG2(SRC_FIFO_LOG2)
    ) trig_fifo_i (
        .CLK_40 (CLK_40),
        .i_rst_n(i_rst_n),
        .i_push (fifo_push),
        .i_data (fifo_din),
        .i_pop  (i_pop),
        .o_data (fifo_dout),
        .o_empty(fifo_empty),
        .o_full (),
        .o_level(fifo_level)
    );

    // hold while a number word waits so its timestamp follows directly
    assign o_src.valid = ~fifo_empty;
    assign o_src.hold  = ~fifo_empty & (word_hdr_t'(fifo_dout[31:28]) == HDR_TRIG_NUM);
    assign o_src.data  = fifo_dout;

    assign o_trig_cnt = trig_cnt;
    assign o_lost_cnt = lost_cnt;

endmodule

/* hw/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
    parameter int DEPTH_LOG2 = 3
) (
    input  logic                    CLK_40,
    input  logic                    i_rst_n,
    input  logic                    i_push,
    input  readout_pkg::data_word_t i_data,
    input  logic                    i_pop,
    output readout_pkg::data_word_t o_data,
    output logic                    o_empty,
    output logic                    o_full,
    output logic [DEPTH_LOG2:0]     o_level
);
    import readout_pkg::*;

    // storage array
    data_word_t mem [2 ** DEPTH_LOG2];

    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_push;
    logic                  do_pop;

    // msb of count set only when every slot is taken
    assign o_full  = count[DEPTH_LOG2];
    assign o_empty = (count == '0);
    assign o_level = count;

    // pushes into a full fifo and pops from an empty one are ignored
    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    // head word always on the output
    assign o_data = mem[rd_ptr];

    always_ff @(posedge CLK_40)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // level follows push and pop together
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_readout \
        -f verilog.f -o sim_readout \
    && ./obj_dir/sim_readout \
    || exit 1

/* test/tb_readout.sv */
`timescale 1ns/1ps

module tb_readout;
    import readout_pkg::*;

    // step kinds of the stimulus table
    typedef enum logic [3:0] {
        K_WR,       // arg = address, exp_val = write data
        K_RD,       // arg = address, exp_val = read data
        K_RD_ERR,   // arg = address, pslverr expected
        K_TRIG,     // arg = number of trigger pulses
        K_TDC,      // arg = number of pulses, exp_val = length or 0 for random
        K_TRIG_TDC, // trigger pair meets a random tdc word at the arbiter
        K_IDLE,     // arg = cycles
        K_DRAIN,    // arg = words to pop and check
        K_EMPTY     // o_rd_valid must be low
    } step_kind_t;

    typedef struct packed {
        step_kind_t  kind;
        logic [31:0] arg;
        logic [31:0] exp_val;
    } step_t;

    localparam int NUM_STEPS = 45;
    // trigger fifo of 8 words holds 4 pairs
    localparam int TRIG_PAIRS_MAX = 4;

    localparam step_t STEPS [NUM_STEPS] = '{
        // reset values
        '{K_EMPTY,    32'd0,               32'd0},
        '{K_RD,       32'(REG_CTRL),       32'd0},
        '{K_RD,       32'(REG_TRIG_CNT),   32'd0},
        '{K_RD,       32'(REG_LOST),       32'd0},
        '{K_RD,       32'(REG_STATUS),     32'd0},
        // both sources on with pairs and tdc words mixed
        '{K_WR,       32'(REG_CTRL),       32'd3},
        '{K_TRIG,     32'd1,               32'd0},
        '{K_TDC,      32'd1,               32'd0},
        '{K_TRIG,     32'd1,               32'd0},
        '{K_TDC,      32'd2,               32'd0},
        '{K_TRIG,     32'd1,               32'd0},
        '{K_TDC,      32'd1,               32'd5},
        '{K_DRAIN,    32'd10,              32'd0},
        '{K_TRIG_TDC, 32'd0,               32'd0},
        '{K_TRIG_TDC, 32'd0,               32'd0},
        '{K_DRAIN,    32'd6,               32'd0},
        '{K_RD,       32'(REG_TRIG_CNT),   32'd5},
        // trigger source off so 4 pairs wait and 2 are lost
        '{K_WR,       32'(REG_CTRL),       32'd2},
        '{K_TRIG,     32'd6,               32'd0},
        '{K_IDLE,     32'd10,              32'd0},
        '{K_EMPTY,    32'd0,               32'd0},
        '{K_RD,       32'(REG_LOST),       32'd2},
        '{K_WR,       32'(REG_CTRL),       32'd3},
        '{K_DRAIN,    32'd8,               32'd0},
        '{K_IDLE,     32'd5,               32'd0},
        '{K_EMPTY,    32'd0,               32'd0},
        '{K_RD,       32'(REG_TRIG_CNT),   32'd9},
        // output fifo saturates at 16 without host reads
        '{K_TRIG,     32'd3,               32'd0},
        '{K_TDC,      32'd12,              32'd0},
        '{K_IDLE,     32'd20,              32'd0},
        '{K_RD,       32'(REG_STATUS),     32'd16},
        '{K_IDLE,     32'd30,              32'd0},
        '{K_RD,       32'(REG_STATUS),     32'd16},
        '{K_DRAIN,    32'd18,              32'd0},
        '{K_IDLE,     32'd5,               32'd0},
        '{K_EMPTY,    32'd0,               32'd0},
        // unmapped address then counter clear
        '{K_RD_ERR,   32'h20,              32'd0},
        '{K_WR,       32'(REG_CLEAR),      32'd1},
        '{K_RD,       32'(REG_TRIG_CNT),   32'd0},
        '{K_RD,       32'(REG_LOST),       32'd0},
        '{K_RD,       32'(REG_CLEAR),      32'd0},
        '{K_TRIG,     32'd1,               32'd0},
        '{K_TDC,      32'd1,               32'd0},
        '{K_DRAIN,    32'd3,               32'd0},
        '{K_RD,       32'(REG_TRIG_CNT),   32'd1}
    };

    logic       CLK_40 = 1'b0;
    logic       i_rst_n;
    logic       i_trigger;
    logic       i_tdc_in;
    apb_req_t   i_apb;
    apb_rsp_t   o_apb;
    logic       i_rd_en;
    logic       o_rd_valid;
    data_word_t o_rd_data;

    // scoreboard
    count_t     trig_q [$];
    data_word_t tdc_q [$];
    count_t     next_num;
    logic [11:0] tdc_seq;
    count_t     last_ts;
    logic       expect_ts;
    logic       trig_en_m;
    int         held_pairs;

    int cycle_cnt = 0;
    int cycle_limit = 0;

    readout_top readout_top_i (
        .CLK_40    (CLK_40),
        .i_rst_n   (i_rst_n),
        .i_trigger (i_trigger),
        .i_tdc_in  (i_tdc_in),
        .i_apb     (i_apb),
        .o_apb     (o_apb),
        .i_rd_en   (i_rd_en),
        .o_rd_valid(o_rd_valid),
        .o_rd_data (o_rd_data)
    );

    // 50 MHz style 20 ns period
    always #10 CLK_40 = ~CLK_40;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // watchdog
    always @(posedge CLK_40)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
            report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
    end

    // ends 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge CLK_40);
            #1;
        end
    endtask

    // setup phase then access phase sampled mid cycle
    task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        i_apb.psel    = 1'b1;
        i_apb.penable = 1'b0;
        i_apb.pwrite  = wr;
        i_apb.paddr   = addr;
        i_apb.pwdata  = wdata;
        wait_cycles(1);
        i_apb.penable = 1'b1;
        #5;
        rdata = o_apb.prdata;
        err   = o_apb.pslverr;
        assert (o_apb.pready == 1'b1)
            else report_failure("Error: o_apb.pready = 0, expected 1");
        wait_cycles(1);
        i_apb = '0;
    endtask

    // keep the model in step with register writes
    task automatic note_apb_write(input apb_addr_t addr, input apb_data_t data);
        if (addr == REG_CTRL)
        begin
            trig_en_m = data[0];
            // stored pairs flow out once enabled
            if (trig_en_m)
                held_pairs = 0;
        end
        if (addr == REG_CLEAR && data[0])
        begin
            next_num = '0;
            tdc_seq  = '0;
        end
    endtask

    task automatic trigger_pulse();
        // disabled source keeps pairs until fifo has no room for 2 words
        if (trig_en_m || held_pairs < TRIG_PAIRS_MAX)
        begin
            trig_q.push_back(next_num);
            next_num = next_num + 1;
            if (!trig_en_m)
                held_pairs++;
        end
        i_trigger = 1'b1;
        wait_cycles(2);
        i_trigger = 1'b0;
        wait_cycles(4);
    endtask

    task automatic tdc_pulse(input int len);
        logic [15:0] len16;
        len16 = 16'(len);
        tdc_q.push_back({HDR_TDC, tdc_seq, len16});
        tdc_seq = tdc_seq + 1;
        i_tdc_in = 1'b1;
        wait_cycles(len);
        i_tdc_in = 1'b0;
        wait_cycles(3);
    endtask

    // per source order with the timestamp word right after its number word
    task automatic check_word(input data_word_t w);
        word_hdr_t  hdr;
        count_t     pay;
        count_t     exp_num;
        data_word_t exp_w;
        hdr = w[31:28];
        pay = w[27:0];
        if (expect_ts)
        begin
            assert (hdr == HDR_TRIG_TS)
                else report_failure($sformatf(
                    "Error: o_rd_data header = %0h, expected %0h after a number word",
                    hdr, HDR_TRIG_TS));
            assert (pay > last_ts)
                else report_failure($sformatf(
                    "Error: o_rd_data timestamp = %07h, not above previous %07h",
                    pay, last_ts));
            last_ts   = pay;
            expect_ts = 1'b0;
        end
        else if (hdr == HDR_TRIG_NUM)
        begin
            assert (trig_q.size() > 0)
                else report_failure("a trigger number word arrived that no trigger caused");
            exp_num = trig_q.pop_front();
            assert (pay == exp_num)
                else report_failure($sformatf(
                    "Error: o_rd_data trigger number = %07h, expected %07h", pay, exp_num));
            expect_ts = 1'b1;
        end
        else
        begin
            assert (hdr == HDR_TDC)
                else report_failure($sformatf(
                    "Error: o_rd_data header = %0h, not a known word type", hdr));
            assert (tdc_q.size() > 0)
                else report_failure("a TDC word arrived that no pulse caused");
            exp_w = tdc_q.pop_front();
            assert (w == exp_w)
                else report_failure($sformatf(
                    "Error: o_rd_data = %08h, expected TDC word %08h", w, exp_w));
        end
    endtask

    task automatic drain_words(input int k);
        data_word_t w;
        for (int i = 0; i < k; i++)
        begin
            // wait for the next head word
            while (!o_rd_valid)
                wait_cycles(1);
            w = o_rd_data;
            check_word(w);
            i_rd_en = 1'b1;
            wait_cycles(1);
            i_rd_en = 1'b0;
        end
    endtask

    task automatic apply_step(input step_t st);
        apb_data_t rdata;
        logic      err;
        int        len;
        case (st.kind)
            K_WR:
            begin
                apb_access(st.arg[7:0], 1'b1, st.exp_val, rdata, err);
                assert (!err)
                    else report_failure($sformatf("Error: o_apb.pslverr = 1 on write to %02h",
                                                  st.arg[7:0]));
                note_apb_write(st.arg[7:0], st.exp_val);
            end
            K_RD:
            begin
                apb_access(st.arg[7:0], 1'b0, '0, rdata, err);
                assert (!err)
                    else report_failure($sformatf("Error: o_apb.pslverr = 1 on read of %02h",
                                                  st.arg[7:0]));
                assert (rdata == st.exp_val)
                    else report_failure($sformatf(
                        "Error: o_apb.prdata at %02h = %08h, expected %08h",
                        st.arg[7:0], rdata, st.exp_val));
            end
            K_RD_ERR:
            begin
                apb_access(st.arg[7:0], 1'b0, '0, rdata, err);
                assert (err)
                    else report_failure($sformatf("Error: o_apb.pslverr = 0 at %02h, expected 1",
                                                  st.arg[7:0]));
            end
            K_TRIG:
                repeat (st.arg)
                    trigger_pulse();
            K_TDC:
                for (int i = 0; i < st.arg; i++)
                begin
                    len = (st.exp_val != 0) ? int'(st.exp_val) : int'($urandom_range(1, 40));
                    tdc_pulse(len);
                end
            K_TRIG_TDC:
            begin
                len = $urandom_range(1, 40);
                // tdc word lands in its fifo on the edge the number word moves
                fork
                    tdc_pulse(len);
                    begin
                        wait_cycles(len);
                        trigger_pulse();
                    end
                join
            end
            K_IDLE:
                wait_cycles(st.arg);
            K_DRAIN:
                drain_words(st.arg);
            default:
                assert (!o_rd_valid)
                    else report_failure("Error: o_rd_valid = 1, expected 0");
        endcase
    endtask

    // upper bound of a step in cycles with its random gap
    function automatic int step_bound(input step_t st);
        case (st.kind)
            K_WR, K_RD, K_RD_ERR: return 4 + 3;
            K_TRIG:               return int'(st.arg) * 8 + 3;
            K_TDC:                return int'(st.arg) * 48 + 3;
            K_TRIG_TDC:           return 48 + 3;
            K_IDLE:               return int'(st.arg) + 3;
            K_DRAIN:              return int'(st.arg) * 4 + 64;
            default:              return 4;
        endcase
    endfunction

    initial
    begin
        int limit;
        void'($urandom(65));
        i_rst_n   = 1'b0;
        i_trigger = 1'b0;
        i_tdc_in  = 1'b0;
        i_apb     = '0;
        i_rd_en   = 1'b0;
        next_num   = '0;
        tdc_seq    = '0;
        last_ts    = '0;
        expect_ts  = 1'b0;
        trig_en_m  = 1'b0;
        held_pairs = 0;
        // reset plus every step plus margin
        limit = 10 + 200;
        for (int s = 0; s < NUM_STEPS; s++)
            limit += step_bound(STEPS[s]);
        cycle_limit = limit;

        repeat (10) @(posedge CLK_40);
        #1;
        i_rst_n = 1'b1;
        wait_cycles(2);

        for (int s = 0; s < NUM_STEPS; s++)
        begin
            apply_step(STEPS[s]);
            wait_cycles($urandom_range(0, 3));
        end

        if (trig_q.size() == 0 && tdc_q.size() == 0 && !expect_ts)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            report_failure("expected words were left over at the end of the run");
        end
    end

endmodule

/* verilog.f */
hw/readout_pkg.sv
hw/word_fifo.sv
hw/trigger_recorder.sv
hw/tdc_recorder.sv
hw/rr_arbiter.sv
hw/apb_regs.sv
hw/readout_top.sv
test/tb_readout.sv
